/* sim/resource_tests.txt */
# C adr data | E adr expected | W handle arg_a arg_b
# R and D: handle arg_a dest block commit_id, every field in hex
E 00 00000000
E 04 00000000
C 04 fffffff5
E 04 00000005
C 0c ffffffff
E 0c 00000000
E c4 00000000
C 04 00000000
C 00 00000001
E 00 00000001
W 10 0003 1234
W 20 0010 8001
W f0 1215 7abc
R 10 0003 1 a5 01
R 30 0000 2 5a 02
R 05 0000 3 33 03
E 4c 00007abc
E 8c 00033300
C 04 00000005
W 41 0000 c0de
R 40 0001 4 11 04
R 41 0000 5 12 05
C 04 0000000f
R 40 0001 6 13 06
R 3f 0002 7 14 07
C 04 00000000
C 00 00000003
E 00 00000003
R 10 0003 1 77 08
E 84 0001a500
R 20 0010 2 78 09
C 00 00000001
E 84 00087700
C 00 00000000
D 20 0010 8 99 0a
E 60 ffff8001
E a0 000a99ff

/* vlog.f */
hdl/core_pkg.sv
hdl/resource_branch.sv
hdl/resource_memory.sv
hdl/resource_writeback.sv
hdl/resource_regs.sv
hdl/resource_unit_top.sv
sim/resource_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module resource_unit_tb -f vlog.f -o resource_unit_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/resource_unit_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "$out" | grep -qx "TEST PASSED" || exit 1
exit 0

/* sim/resource_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module resource_unit_tb;
	import core_pkg::*;

	localparam int WB_TIMEOUT = 20;
	localparam int ISSUE_TIMEOUT = 200;
	localparam int STALL_TIMEOUT = 40;
	localparam int POLL_LIMIT = 60;
	localparam int PROBE_CYCLES = 20;

	logic clk;
	logic reset;
	logic in_valid;
	wire in_ready;
	logic write;
	handle_t handle;
	data_t arg_a;
	data_t arg_b;
	dest_t dest;
	block_t block;
	commit_id_t commit_id;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat_w;
	wire wb_dat_t wb_dat_r;
	wire wb_ack;

	// reference models of the resource store and the result file
	data_t mem_model [0:MEM_WORDS-1];
	result_t file_result [0:RESULT_ENTRIES-1];
	block_t file_block [0:RESULT_ENTRIES-1];
	commit_id_t file_cid [0:RESULT_ENTRIES-1];

	// one read in flight at most since the branch is one deep
	logic pend_valid;
	dest_t pend_dest;
	result_t pend_result;
	block_t pend_block;
	commit_id_t pend_cid;

	logic enable_m;
	logic hold_m;
	int errors;
	int tests;
	int failed_tests;
	logic line_failed;
	logic [31:0] rand_state;

	resource_unit_top resource_unit_top_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.write(write),
		.handle(handle),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.dest(dest),
		.block(block),
		.commit_id(commit_id),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// high word layout of a result file entry
	function automatic logic [31:0] pack_result_hi(input result_t r, input block_t b,
			input commit_id_t c);
		return {10'b0, c, b, r[39:32]};
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			errors++;
			line_failed = 1'b1;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		errors++;
		line_failed = 1'b1;
	endtask

	// called on a falling edge and returns on the falling edge where ack is seen
	task automatic wb_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
			output wb_dat_t rdata);
		int n;
		n = 0;
		rdata = '0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < WB_TIMEOUT);
		if (wb_ack) begin
			rdata = wb_dat_r;
		end else begin
			report_failure($sformatf("no Wishbone ack for address %h", adr));
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic read_entry(input dest_t d, output wb_dat_t lo, output wb_dat_t hi);
		wb_access(1'b0, REG_RESULT_LO + {2'b00, d, 2'b00}, 32'h0, lo);
		wb_access(1'b0, REG_RESULT_HI + {2'b00, d, 2'b00}, 32'h0, hi);
	endtask

	task automatic check_pending(input int polls);
		wb_dat_t lo;
		wb_dat_t hi;
		wb_dat_t exp_lo;
		wb_dat_t exp_hi;
		int n;
		exp_lo = pend_result[31:0];
		exp_hi = pack_result_hi(pend_result, pend_block, pend_cid);
		n = 0;
		do begin
			read_entry(pend_dest, lo, hi);
			n++;
		end while ((lo !== exp_lo || hi !== exp_hi) && n < polls);
		if (polls > 1 && (lo !== exp_lo || hi !== exp_hi)) begin
			report_failure($sformatf("result for dest %0d never reached the result file",
				pend_dest));
		end
		compare("result_lo", lo, exp_lo);
		compare("result_hi", hi, exp_hi);
		file_result[pend_dest] = pend_result;
		file_block[pend_dest] = pend_block;
		file_cid[pend_dest] = pend_cid;
		pend_valid = 1'b0;
	endtask

	task automatic settle_results();
		if (pend_valid && enable_m && !hold_m) begin
			check_pending(POLL_LIMIT);
		end
	endtask

	task automatic take_read(input logic [31:0] h, input logic [31:0] a, input logic [31:0] d,
			input logic [31:0] blk, input logic [31:0] cid);
		handle_t addr;
		data_t word;
		addr = h[7:0] + a[7:0];
		word = mem_model[addr];
		pend_result = word[15] ? {24'hff_ffff, word} : {24'h00_0000, word};
		pend_dest = d[DEST_W-1:0];
		pend_block = blk[BLOCK_W-1:0];
		pend_cid = cid[COMMIT_ID_W-1:0];
		pend_valid = 1'b1;
	endtask

	task automatic present_op(input logic wr, input logic [31:0] h, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] d, input logic [31:0] blk,
			input logic [31:0] cid);
		write = wr;
		handle = h[HANDLE_W-1:0];
		arg_a = a[DATA_W-1:0];
		arg_b = b[DATA_W-1:0];
		dest = d[DEST_W-1:0];
		block = blk[BLOCK_W-1:0];
		commit_id = cid[COMMIT_ID_W-1:0];
		in_valid = 1'b1;
	endtask

	// in_ready seen high on a falling edge means the next rising edge accepts
	task automatic wait_accept(input int limit, output logic accepted);
		int n;
		n = 0;
		while (!in_ready && n < limit) begin
			@(negedge clk);
			n++;
		end
		accepted = in_ready;
		if (accepted) begin
			@(negedge clk);
			// the branch is busy with the operation just taken
			compare("in_ready", {31'b0, in_ready}, 32'h0);
		end
		in_valid = 1'b0;
	endtask

	task automatic run_issue(input logic wr, input logic [31:0] h, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] d, input logic [31:0] blk,
			input logic [31:0] cid);
		logic stall;
		logic accepted;
		handle_t addr;
		wb_dat_t lo;
		wb_dat_t hi;
		stall = pend_valid && (hold_m || !enable_m);
		present_op(wr, h, a, b, d, blk, cid);
		wait_accept(stall ? STALL_TIMEOUT : ISSUE_TIMEOUT, accepted);
		if (stall) begin
			if (accepted) begin
				report_failure("operation accepted while a read result was still held");
			end else begin
				$display("in_ready stayed low for %0d cycles under writeback hold, as expected",
					STALL_TIMEOUT);
				// held entry must still show its previous contents
				read_entry(pend_dest, lo, hi);
				compare("result_lo", lo, file_result[pend_dest][31:0]);
				compare("result_hi", hi, pack_result_hi(file_result[pend_dest],
					file_block[pend_dest], file_cid[pend_dest]));
			end
		end else if (!accepted) begin
			report_failure($sformatf("in_ready did not rise within %0d cycles", ISSUE_TIMEOUT));
		end else begin
			// the earlier read has retired by the time a new one is taken
			if (pend_valid) begin
				check_pending(1);
			end
			if (wr) begin
				addr = h[7:0] + a[7:0];
				mem_model[addr] = b[DATA_W-1:0];
			end else begin
				take_read(h, a, d, blk, cid);
			end
		end
	endtask

	task automatic disabled_probe(input logic [31:0] h, input logic [31:0] a,
			input logic [31:0] d, input logic [31:0] blk, input logic [31:0] cid);
		wb_dat_t rdata;
		logic accepted;
		present_op(1'b0, h, a, 32'h0, d, blk, cid);
		repeat (PROBE_CYCLES) begin
			compare("in_ready", {31'b0, in_ready}, 32'h0);
			@(negedge clk);
		end
		wb_access(1'b1, REG_CTRL, 32'h1, rdata);
		enable_m = 1'b1;
		hold_m = 1'b0;
		wait_accept(ISSUE_TIMEOUT, accepted);
		if (accepted) begin
			take_read(h, a, d, blk, cid);
		end else begin
			report_failure("operation was not accepted after enable was set");
		end
	endtask

	task automatic run_line(input int fd, input logic [7:0] op);
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		logic [31:0] a4;
		logic [31:0] a5;
		wb_dat_t rdata;
		int code;
		int want;
		line_failed = 1'b0;
		tests++;
		a1 = '0;
		a2 = '0;
		a3 = '0;
		a4 = '0;
		a5 = '0;
		code = 0;
		want = 0;
		case (op)
			"C": begin
				want = 2;
				code = $fscanf(fd, "%h %h", a1, a2);
				settle_results();
				wb_access(1'b1, a1[7:0], a2, rdata);
				if (a1[7:0] == REG_CTRL) begin
					enable_m = a2[CTRL_ENABLE];
					hold_m = a2[CTRL_HOLD];
				end
				settle_results();
			end
			"E": begin
				want = 2;
				code = $fscanf(fd, "%h %h", a1, a2);
				settle_results();
				wb_access(1'b0, a1[7:0], 32'h0, rdata);
				compare("wb_dat_r", rdata, a2);
			end
			"W": begin
				want = 3;
				code = $fscanf(fd, "%h %h %h", a1, a2, a3);
				run_issue(1'b1, a1, a2, a3, 32'h0, 32'h0, 32'h0);
			end
			"R": begin
				want = 5;
				code = $fscanf(fd, "%h %h %h %h %h", a1, a2, a3, a4, a5);
				run_issue(1'b0, a1, a2, 32'h0, a3, a4, a5);
			end
			"D": begin
				want = 5;
				code = $fscanf(fd, "%h %h %h %h %h", a1, a2, a3, a4, a5);
				disabled_probe(a1, a2, a3, a4, a5);
			end
			default: begin
				report_failure($sformatf("unknown op %c in tests file", op));
			end
		endcase
		if (code != want) begin
			report_failure($sformatf("test %0d has %0d operands, expected %0d", tests, code, want));
		end
		if (line_failed) begin
			failed_tests++;
			$display("test %0d op %c: fail", tests, op);
		end else begin
			$display("test %0d op %c: ok", tests, op);
		end
	endtask

	initial begin
		int fd;
		int code;
		int ch;
		logic [7:0] op;
		logic done;
		reset = 1'b1;
		in_valid = 1'b0;
		write = 1'b0;
		handle = '0;
		arg_a = '0;
		arg_b = '0;
		dest = '0;
		block = '0;
		commit_id = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		line_failed = 1'b0;
		rand_state = 32'd76824;
		pend_valid = 1'b0;
		pend_dest = '0;
		pend_result = '0;
		pend_block = '0;
		pend_cid = '0;
		enable_m = 1'b0;
		hold_m = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_model[i] = '0;
		end
		for (int i = 0; i < RESULT_ENTRIES; i++) begin
			file_result[i] = '0;
			file_block[i] = '0;
			file_cid[i] = '0;
		end
		repeat (16) @(negedge clk);
		reset = 1'b0;
		fd = $fopen("sim/resource_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/resource_tests.txt");
			errors++;
		end else begin
			done = 1'b0;
			while (!done) begin
				code = $fscanf(fd, " %c", op);
				if (code != 1) begin
					done = 1'b1;
				end else if (op == "#") begin
					ch = $fgetc(fd);
					while (ch != 10 && ch != -1) begin
						ch = $fgetc(fd);
					end
				end else begin
					run_line(fd, op);
					// idle gap of 0 to 3 cycles
					rand_state = next_random(rand_state);
					repeat (rand_state[1:0]) @(negedge clk);
				end
			end
			$fclose(fd);
			if (pend_valid) begin
				if (enable_m && !hold_m) begin
					check_pending(POLL_LIMIT);
				end else begin
					report_failure("a read result was still held at the end of the run");
				end
			end
		end
		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0 && tests > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/resource_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module resource_unit_top (
	input wire clk,
	input wire reset,

	input wire in_valid,
	output wire in_ready,
	input wire write,
	input wire core_pkg::handle_t handle,
	input wire core_pkg::data_t arg_a,
	input wire core_pkg::data_t arg_b,
	input wire core_pkg::dest_t dest,
	input wire core_pkg::block_t block,
	input wire core_pkg::commit_id_t commit_id,

	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire core_pkg::wb_adr_t wb_adr,
	input wire core_pkg::wb_dat_t wb_dat_w,
	output wire core_pkg::wb_dat_t wb_dat_r,
	output wire wb_ack
);
	import core_pkg::*;

	wire enable;
	wire hold;
	wire lat_t latency;

	wire read_req;
	wire write_req;
	wire handle_t mem_handle;
	wire data_t mem_arg_a;
	wire data_t mem_arg_b;
	wire read_valid;
	wire data_t read_data;
	wire write_ack;

	wire out_valid;
	wire out_ready;
	wire result_t result;
	wire dest_t wb_dest;
	wire block_t wb_block;
	wire commit_id_t wb_commit_id;

	wire dest_t rd_index;
	wire result_t rd_result;
	wire block_t rd_block;
	wire commit_id_t rd_commit_id;

	resource_branch branch_i (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.write(write),
		.handle(handle),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.dest(dest),
		.block(block),
		.commit_id(commit_id),
		.read_req(read_req),
		.write_req(write_req),
		.mem_handle(mem_handle),
		.mem_arg_a(mem_arg_a),
		.mem_arg_b(mem_arg_b),
		.read_valid(read_valid),
		.read_data(read_data),
		.write_ack(write_ack),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.dest_out(wb_dest),
		.block_out(wb_block),
		.commit_id_out(wb_commit_id)
	);

	resource_memory memory_i (
		.clk(clk),
		.reset(reset),
		.latency(latency),
		.read_req(read_req),
		.write_req(write_req),
		.handle(mem_handle),
		.arg_a(mem_arg_a),
		.arg_b(mem_arg_b),
		.read_valid(read_valid),
		.read_data(read_data),
		.write_ack(write_ack)
	);

	resource_writeback writeback_i (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.dest(wb_dest),
		.block(wb_block),
		.commit_id(wb_commit_id),
		.rd_index(rd_index),
		.rd_result(rd_result),
		.rd_block(rd_block),
		.rd_commit_id(rd_commit_id)
	);

	resource_regs regs_i (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.enable(enable),
		.hold(hold),
		.latency(latency),
		.rd_index(rd_index),
		.rd_result(rd_result),
		.rd_block(rd_block),
		.rd_commit_id(rd_commit_id)
	);

endmodule

`default_nettype wire

/* hdl/resource_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module resource_regs (
	input wire clk,
	input wire reset,

	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire core_pkg::wb_adr_t wb_adr,
	input wire core_pkg::wb_dat_t wb_dat_w,
	output core_pkg::wb_dat_t wb_dat_r,
	output logic wb_ack,

	output logic enable,
	output logic hold,
	output core_pkg::lat_t latency,

	output core_pkg::dest_t rd_index,
	input wire core_pkg::result_t rd_result,
	input wire core_pkg::block_t rd_block,
	input wire core_pkg::commit_id_t rd_commit_id
);
	import core_pkg::*;

	logic cycle;
	logic sel_lo;
	logic sel_hi;
	wb_dat_t rd_data;

	// one access per cycle pair, ack drops before the next is taken
	assign cycle = wb_cyc && wb_stb && !wb_ack;

	assign rd_index = wb_adr[5:2];
	assign sel_lo = (wb_adr[7:6] == REG_RESULT_LO[7:6]) && (wb_adr[1:0] == 2'b00);
	assign sel_hi = (wb_adr[7:6] == REG_RESULT_HI[7:6]) && (wb_adr[1:0] == 2'b00);

	always_comb begin
		rd_data = '0;
		if (wb_adr == REG_CTRL) begin
			rd_data[CTRL_ENABLE] = enable;
			rd_data[CTRL_HOLD] = hold;
		end else if (wb_adr == REG_LATENCY) begin
			rd_data[LAT_W-1:0] = latency;
		end else if (sel_lo) begin
			rd_data = rd_result[31:0];
		end else if (sel_hi) begin
			rd_data[7:0] = rd_result[FULL_W-1:32];
			rd_data[15:8] = rd_block;
			rd_data[16 +: COMMIT_ID_W] = rd_commit_id;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			enable <= 1'b0;
			hold <= 1'b0;
			latency <= '0;
		end else begin
			wb_ack <= cycle;
			if (cycle && wb_we) begin
				case (wb_adr)
					REG_CTRL: begin
						enable <= wb_dat_w[CTRL_ENABLE];
						hold <= wb_dat_w[CTRL_HOLD];
					end
					REG_LATENCY: begin
						latency <= wb_dat_w[LAT_W-1:0];
					end
					default: ;
				endcase
			end
		end
	end

	// read data is sampled together with ack
	always_ff @(posedge clk) begin
		if (cycle && !wb_we) begin
			wb_dat_r <= rd_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/resource_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module resource_writeback (
	input wire clk,
	input wire reset,
	input wire hold,

	input wire out_valid,
	output logic out_ready,
	input wire core_pkg::result_t result,
	input wire core_pkg::dest_t dest,
	input wire core_pkg::block_t block,
	input wire core_pkg::commit_id_t commit_id,

	input wire core_pkg::dest_t rd_index,
	output core_pkg::result_t rd_result,
	output core_pkg::block_t rd_block,
	output core_pkg::commit_id_t rd_commit_id
);
	import core_pkg::*;

	result_t result_q [0:RESULT_ENTRIES-1];
	block_t block_q [0:RESULT_ENTRIES-1];
	commit_id_t commit_id_q [0:RESULT_ENTRIES-1];

	assign out_ready = !hold;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < RESULT_ENTRIES; i++) begin
				result_q[i] <= '0;
				block_q[i] <= '0;
				commit_id_q[i] <= '0;
			end
		end else if (out_valid && out_ready) begin
			result_q[dest] <= result;
			block_q[dest] <= block;
			commit_id_q[dest] <= commit_id;
		end
	end

	// read port for the register block
	assign rd_result = result_q[rd_index];
	assign rd_block = block_q[rd_index];
	assign rd_commit_id = commit_id_q[rd_index];

endmodule

`default_nettype wire

/* hdl/resource_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module resource_memory (
	input wire clk,
	input wire reset,
	input wire core_pkg::lat_t latency,
	input wire read_req,
	input wire write_req,
	input wire core_pkg::handle_t handle,
	input wire core_pkg::data_t arg_a,
	input wire core_pkg::data_t arg_b,
	output logic read_valid,
	output core_pkg::data_t read_data,
	output logic write_ack
);
	import core_pkg::*;

	data_t mem [0:MEM_WORDS-1];
	handle_t addr;
	lat_t count;
	logic busy;
	logic start;
	logic fire;

	// handle plus offset, wraps at the top of the store
	assign addr = handle + arg_a[HANDLE_W-1:0];

	// the request stays high during the response cycle, don't restart on it
	assign start = (read_req || write_req) && !busy && !read_valid && !write_ack;
	assign fire = busy ? (count == lat_t'(1)) : (start && latency == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
			read_valid <= 1'b0;
			write_ack <= 1'b0;
		end else begin
			read_valid <= fire && read_req;
			write_ack <= fire && write_req;
			if (fire) begin
				busy <= 1'b0;
			end else if (busy) begin
				count <= count - lat_t'(1);
			end else if (start) begin
				busy <= 1'b1;
				count <= latency;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire && write_req) begin
			mem[addr] <= arg_b;
		end
		if (fire && read_req) begin
			read_data <= mem[addr];
		end
	end

endmodule

`default_nettype wire

/* hdl/resource_branch.sv */
`timescale 1ns/1ps
`default_nettype none

module resource_branch (
	input wire clk,
	input wire reset,
	input wire enable,

	input wire in_valid,
	output logic in_ready,
	input wire write,
	input wire core_pkg::handle_t handle,
	input wire core_pkg::data_t arg_a,
	input wire core_pkg::data_t arg_b,
	input wire core_pkg::dest_t dest,
	input wire core_pkg::block_t block,
	input wire core_pkg::commit_id_t commit_id,

	output logic read_req,
	output logic write_req,
	output core_pkg::handle_t mem_handle,
	output core_pkg::data_t mem_arg_a,
	output core_pkg::data_t mem_arg_b,
	input wire read_valid,
	input wire core_pkg::data_t read_data,
	input wire write_ack,

	output logic out_valid,
	input wire out_ready,
	output core_pkg::result_t result,
	output core_pkg::dest_t dest_out,
	output core_pkg::block_t block_out,
	output core_pkg::commit_id_t commit_id_out
);
	import core_pkg::*;

	branch_state_t state;
	logic write_q;
	dest_t dest_q;
	block_t block_q;
	commit_id_t commit_id_q;
	logic accept;
	logic read_done;

	// enable gates acceptance, so nothing is taken while the branch is frozen
	assign in_ready = enable && (state == BR_IDLE);
	assign accept = in_valid && in_ready;
	assign out_valid = (state == BR_DONE);

	assign read_req = (state == BR_REQ) && !write_q;
	assign write_req = (state == BR_REQ) && write_q;
	assign read_done = enable && read_req && read_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= BR_IDLE;
		end else if (enable) begin
			case (state)
				BR_IDLE: begin
					if (accept) begin
						state <= BR_REQ;
					end
				end
				BR_REQ: begin
					if (write_q && write_ack) begin
						state <= BR_IDLE;
					end else if (!write_q && read_valid) begin
						state <= BR_DONE;
					end
				end
				BR_DONE: begin
					if (out_ready) begin
						state <= BR_IDLE;
					end
				end
				default: state <= BR_IDLE;
			endcase
		end
	end

	// operation fields, held for the memory request
	always_ff @(posedge clk) begin
		if (accept) begin
			write_q <= write;
			mem_handle <= handle;
			mem_arg_a <= arg_a;
			mem_arg_b <= arg_b;
			dest_q <= dest;
			block_q <= block;
			commit_id_q <= commit_id;
		end
	end

	always_ff @(posedge clk) begin
		if (read_done) begin
			result <= {{(FULL_W - DATA_W){read_data[DATA_W-1]}}, read_data};
			dest_out <= dest_q;
			block_out <= block_q;
			commit_id_out <= commit_id_q;
		end
	end

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int DATA_W = 16;
	localparam int HANDLE_W = 8;
	localparam int BLOCK_W = 8;
	localparam int COMMIT_ID_W = 6;
	localparam int DEST_W = 4;
	localparam int FULL_W = 2 * DATA_W + 8;
	localparam int WB_ADR_W = 8;
	localparam int WB_DAT_W = 32;
	localparam int LAT_W = 4;

	localparam int MEM_WORDS = 2 ** HANDLE_W;
	localparam int RESULT_ENTRIES = 2 ** DEST_W;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [HANDLE_W-1:0] handle_t;
	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [COMMIT_ID_W-1:0] commit_id_t;
	typedef logic [DEST_W-1:0] dest_t;
	typedef logic [FULL_W-1:0] result_t;
	typedef logic [WB_ADR_W-1:0] wb_adr_t;
	typedef logic [WB_DAT_W-1:0] wb_dat_t;
	typedef logic [LAT_W-1:0] lat_t;

	typedef enum logic [1:0] {BR_IDLE, BR_REQ, BR_DONE} branch_state_t;

	// register map, byte addresses
	localparam wb_adr_t REG_CTRL = 8'h00;
	localparam wb_adr_t REG_LATENCY = 8'h04;
	localparam wb_adr_t REG_RESULT_LO = 8'h40;
	localparam wb_adr_t REG_RESULT_HI = 8'h80;

	// REG_CTRL bits
	localparam int CTRL_ENABLE = 0;
	localparam int CTRL_HOLD = 1;

endpackage

`default_nettype wire
